//--- fas_pkg.sv
package fas_pkg;

  ////////////////////////////////////////////////////////////
  // Data types
  ////////////////////////////////////////////////////////////

  typedef logic signed [15:0] sample_t;  // One audio sample
  typedef logic signed [19:0] coef_t;    // Q4.16 coefficient
  typedef logic signed [41:0] acc_t;     // 36 bit product, 5 bits growth, 1 spare

  // Filter output as seen by the frame assembler and the top ports
  typedef struct packed {
    logic    valid;   // Sample is one new filter output
    sample_t sample;  // Rounded filter result
  } fir_out_t;

  ////////////////////////////////////////////////////////////
  // Filter constants
  ////////////////////////////////////////////////////////////

  localparam int NUM_TAPS = 32;
  localparam int FIR_FILL = 34;  // Accepted samples before output is valid

  // Symmetric low-pass taps, entry k equals entry NUM_TAPS-1-k
  localparam coef_t FIR_COEFS [NUM_TAPS] = '{
    20'hFFF9E, 20'hFFF86, 20'hFFFA7, 20'h0003B,  // Taps 0 to 3
    20'h0014B, 20'h0024A, 20'h00222, 20'hFFFE4,  // Taps 4 to 7
    20'hFFBC5, 20'hFF7CA, 20'hFF74E, 20'hFFD74,  // Taps 8 to 11
    20'h00B1A, 20'h01DAC, 20'h02F9E, 20'h03AA9,  // Taps 12 to 15, center
    20'h03AA9, 20'h02F9E, 20'h01DAC, 20'h00B1A,  // Mirror starts here
    20'hFFD74, 20'hFF74E, 20'hFF7CA, 20'hFFBC5,
    20'hFFFE4, 20'h00222, 20'h0024A, 20'h0014B,
    20'h0003B, 20'hFFFA7, 20'hFFF86, 20'hFFF9E
  };

  ////////////////////////////////////////////////////////////
  // Frame constants
  ////////////////////////////////////////////////////////////

  localparam int DEFAULT_FRAME_LEN = 16;  // Samples per frame

endpackage

//--- fir_filter.sv
`timescale 1ns/100ps

module fir_filter import fas_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     data_valid,
  input  sample_t  data,
  output fir_out_t fir_out
);

  localparam int HALF_TAPS = NUM_TAPS / 2;
  localparam int FILL_W    = $clog2(FIR_FILL + 1);
  localparam int FRAC_BITS = 16;                       // Fraction bits of coef_t
  localparam int SAMPLE_W  = $bits(sample_t);
  localparam int ACC_MSB   = $bits(acc_t) - 1;
  localparam int KEEP_MSB  = FRAC_BITS + SAMPLE_W - 2;  // Top magnitude bit kept

  typedef logic signed [SAMPLE_W:0] pair_t;  // Sum of two mirrored taps
  typedef logic [FILL_W-1:0]        fill_t;

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  sample_t delay_line [NUM_TAPS];  // Entry 0 holds the newest sample
  pair_t   tap_pair [HALF_TAPS];
  acc_t    acc_next;
  acc_t    acc_q;
  fill_t   fill_cnt;
  logic    acc_neg;
  sample_t acc_trunc;
  sample_t acc_round;

  ////////////////////////////////////////////////////////////
  // Multiply-accumulate
  ////////////////////////////////////////////////////////////

  // The taps are symmetric, so mirrored samples share one multiplier
  always_comb begin
    for (int k = 0; k < HALF_TAPS; k++) begin
      tap_pair[k] = pair_t'(delay_line[k]) + pair_t'(delay_line[NUM_TAPS-1-k]);
    end
  end

  always_comb begin
    acc_next = '0;
    for (int k = 0; k < HALF_TAPS; k++) begin
      acc_next = acc_next + acc_t'(tap_pair[k]) * acc_t'(FIR_COEFS[k]);
    end
  end

  ////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////

  // Delay line only moves on accepted samples, a gap keeps its contents
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int k = 0; k < NUM_TAPS; k++) begin
        delay_line[k] <= '0;
      end
    end else if (data_valid) begin
      delay_line[0] <= data;
      for (int k = 1; k < NUM_TAPS; k++) begin
        delay_line[k] <= delay_line[k-1];
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      acc_q <= '0;
    end else if (data_valid) begin
      acc_q <= acc_next;  // Sum excludes the sample accepted on this edge
    end else begin
      acc_q <= '0;
    end
  end

  // Fill count saturates once the output is valid
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fill_cnt <= '0;
    end else if (!data_valid) begin
      fill_cnt <= '0;  // New run must refill
    end else if (fill_cnt < fill_t'(FIR_FILL)) begin
      fill_cnt <= fill_cnt + fill_t'(1);
    end
  end

  ////////////////////////////////////////////////////////////
  // Output rounding
  ////////////////////////////////////////////////////////////

  assign acc_neg   = acc_q[ACC_MSB];
  assign acc_trunc = {acc_neg, acc_q[KEEP_MSB:FRAC_BITS]};
  assign acc_round = acc_trunc + {{(SAMPLE_W-1){1'b0}}, acc_neg};  // Nudge negatives up

  assign fir_out.valid  = (fill_cnt >= fill_t'(FIR_FILL));
  assign fir_out.sample = acc_round;

endmodule

//--- frame_assembler.sv
`timescale 1ns/100ps

module frame_assembler import fas_pkg::*; #(
  parameter int FRAME_LEN = DEFAULT_FRAME_LEN
) (
  input  logic                     clk,
  input  logic                     rst,
  input  fir_out_t                 fir_out,
  output sample_t [FRAME_LEN-1:0]  frame,
  output logic                     frame_valid
);

  localparam int SLOT_W = (FRAME_LEN > 1) ? $clog2(FRAME_LEN) : 1;

  typedef logic [SLOT_W-1:0] slot_t;

  localparam slot_t LAST_SLOT = slot_t'(FRAME_LEN - 1);

  ////////////////////////////////////////////////////////////
  // Slot counter
  ////////////////////////////////////////////////////////////

  slot_t slot;        // Next slot to be written
  logic  last_write;  // This valid sample completes a frame

  assign last_write = fir_out.valid && (slot == LAST_SLOT);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      slot <= '0;
    end else if (fir_out.valid) begin
      if (slot == LAST_SLOT) begin
        slot <= '0;  // Wrap for the next frame
      end else begin
        slot <= slot + slot_t'(1);
      end
    end
  end

  // Pulse in the cycle where the completed frame is visible
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= last_write;
    end
  end

  ////////////////////////////////////////////////////////////
  // Frame storage
  ////////////////////////////////////////////////////////////

  // Slots keep their value until the counter comes around again
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      frame <= '0;
    end else if (fir_out.valid) begin
      frame[slot] <= fir_out.sample;
    end
  end

endmodule

//--- fas_top.sv
`timescale 1ns/100ps

module fas_top import fas_pkg::*; #(
  parameter int FRAME_LEN = DEFAULT_FRAME_LEN
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     data_valid,
  input  sample_t                  data,
  output fir_out_t                 fir_out,
  output sample_t [FRAME_LEN-1:0]  frame,
  output logic                     frame_valid
);

  ////////////////////////////////////////////////////////////
  // Low-pass filter
  ////////////////////////////////////////////////////////////

  // Filter output also leaves the chip for observation
  fir_filter u_fir (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .fir_out    (fir_out)
  );

  ////////////////////////////////////////////////////////////
  // Serial to parallel
  ////////////////////////////////////////////////////////////

  frame_assembler #(
    .FRAME_LEN (FRAME_LEN)
  ) u_frame (
    .clk         (clk),
    .rst         (rst),
    .fir_out     (fir_out),      // Only valid samples are stored
    .frame       (frame),
    .frame_valid (frame_valid)   // One cycle per completed frame
  );

endmodule

//--- tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;  // Release away from the active edge
  end

  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

//--- tb_fas.sv
`timescale 1ns/100ps

module tb_fas import fas_pkg::*; ();

  localparam int FRAME_LEN    = 16;
  localparam int RESET_CYCLES = 10;
  localparam int FLUSH_CYCLES = 3;    // Covers filter output, frame write and frame pulse
  localparam int IMPULSE_TAIL = 40;   // Covers all 32 taps after the impulse
  localparam int RANDOM_LEN   = 300;
  localparam int GAP_BEFORE   = 50;
  localparam int GAP_AFTER    = 60;
  localparam int EXTREME_RUN  = 36;
  localparam int TEST_CYCLES  = RESET_CYCLES + 1 + FIR_FILL + 1 + IMPULSE_TAIL
                              + RANDOM_LEN + GAP_BEFORE + 1 + GAP_AFTER
                              + 3 * EXTREME_RUN + 6 * FLUSH_CYCLES;
  localparam int MAX_CYCLES   = ((3 * TEST_CYCLES + 999) / 1000) * 1000;

  localparam sample_t FULL_POS = 16'sh7FFF;
  localparam sample_t FULL_NEG = 16'sh8000;

  logic                    clk;
  logic                    rst;
  logic                    data_valid;
  sample_t                 data;
  fir_out_t                fir_out;
  sample_t [FRAME_LEN-1:0] frame;
  logic                    frame_valid;

  ////////////////////////////////////////////////////////////
  // Model state and bookkeeping
  ////////////////////////////////////////////////////////////

  sample_t     hist [$];                // Every accepted sample since reset
  int          run_len = 0;             // Accepted samples in the current run
  logic        exp_valid = 1'b0;
  sample_t     exp_sample = '0;
  logic        exp_frame_valid = 1'b0;
  sample_t     model_frame [FRAME_LEN];
  int          model_slot = 0;
  logic        armed = 1'b0;            // Outputs are defined after the first reset edge
  string       test_name = "reset";
  int          errors_at_start = 0;
  int          check_count = 0;
  int          error_count = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          frame_pulses = 0;
  int          cycle_count = 0;
  logic [15:0] lfsr_state = 16'd16;

  tb_clock_gen #(
    .PERIOD_NS    (4),
    .RESET_CYCLES (RESET_CYCLES)
  ) u_clk (
    .clk (clk),
    .rst (rst)
  );

  fas_top #(
    .FRAME_LEN (FRAME_LEN)
  ) uut (
    .clk         (clk),
    .rst         (rst),
    .data_valid  (data_valid),
    .data        (data),
    .fir_out     (fir_out),
    .frame       (frame),
    .frame_valid (frame_valid)
  );

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Sums the samples before position pos with zeros where history runs out
  function automatic sample_t ref_filter(input int pos);
    longint      acc;
    logic [63:0] acc_bits;
    sample_t     trunc;
    acc = 0;
    for (int k = 0; k < NUM_TAPS; k++) begin
      if (pos - 1 - k >= 0) begin
        acc += longint'(FIR_COEFS[k]) * longint'(hist[pos-1-k]);
      end
    end
    acc_bits = acc;
    trunc = {acc_bits[63], acc_bits[30:16]};  // Sign bit followed by bits 30 to 16
    return trunc + (acc_bits[63] ? sample_t'(1) : sample_t'(0));
  endfunction

  // 16 bit Galois LFSR stepped once per output bit
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  task automatic draw_sample(output sample_t s);
    for (int i = 0; i < 16; i++) begin
      s[i] = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic check_equal(input string what,
                             input logic signed [31:0] expected,
                             input logic signed [31:0] actual);
    check_count++;
    assert (expected === actual) else begin
      $display("error %s: %s expected %0d actual %0d", test_name, what, expected, actual);
      error_count++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Comparison on every rising edge
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    logic next_frame_valid;
    next_frame_valid = 1'b0;
    if (armed) begin
      check_equal("fir_out valid", exp_valid, fir_out.valid);
      check_equal("fir_out sample", exp_sample, fir_out.sample);
      check_equal("frame_valid", exp_frame_valid, frame_valid);
      if (exp_frame_valid) begin
        for (int i = 0; i < FRAME_LEN; i++) begin
          check_equal($sformatf("frame slot %0d", i), model_frame[i], frame[i]);
        end
      end
    end
    if (frame_valid === 1'b1) begin
      frame_pulses++;
    end
    if (rst) begin
      hist.delete();
      run_len = 0;
      exp_valid = 1'b0;
      exp_sample = '0;
      exp_frame_valid = 1'b0;
      model_slot = 0;
      for (int i = 0; i < FRAME_LEN; i++) begin
        model_frame[i] = '0;
      end
    end else begin
      // Frame model takes the filter output presented at this edge
      if (exp_valid) begin
        model_frame[model_slot] = exp_sample;
        if (model_slot == FRAME_LEN - 1) begin
          model_slot = 0;
          next_frame_valid = 1'b1;
        end else begin
          model_slot++;
        end
      end
      exp_frame_valid = next_frame_valid;
      if (data_valid) begin
        hist.push_back(data);
        run_len++;
        exp_sample = ref_filter(hist.size() - 1);
        exp_valid = (run_len >= FIR_FILL);
      end else begin
        run_len = 0;             // Gap restarts the fill
        exp_valid = 1'b0;
        exp_sample = '0;
      end
    end
    armed = 1'b1;
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  initial begin
    wait (cycle_count >= MAX_CYCLES);
    $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  task automatic send_sample(input sample_t s);
    @(negedge clk);
    data_valid = 1'b1;
    data = s;
  endtask

  task automatic idle_cycles(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      data_valid = 1'b0;
      data = '0;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    errors_at_start = error_count;
  endtask

  task automatic report_test();
    tests_run++;
    if (error_count == errors_at_start) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, error_count - errors_at_start);
    end
  endtask

  initial begin
    int      pulses_before;
    sample_t s;
    data_valid = 1'b0;
    data = '0;

    @(negedge rst);
    idle_cycles(FLUSH_CYCLES);
    report_test();

    start_test("impulse");
    repeat (FIR_FILL) send_sample('0);
    send_sample(sample_t'(4096));
    repeat (IMPULSE_TAIL) send_sample('0);
    idle_cycles(FLUSH_CYCLES);
    report_test();

    start_test("random_stream");
    pulses_before = frame_pulses;
    repeat (RANDOM_LEN) begin
      draw_sample(s);
      send_sample(s);
    end
    idle_cycles(FLUSH_CYCLES);
    assert (frame_pulses - pulses_before >= (RANDOM_LEN - FIR_FILL + 1) / FRAME_LEN) else begin
      $display("%s: only %0d frames were completed", test_name, frame_pulses - pulses_before);
      error_count++;
    end
    report_test();

    start_test("gap_restart");
    repeat (GAP_BEFORE) begin
      draw_sample(s);
      send_sample(s);
    end
    idle_cycles(1);                      // Single gap cycle mid stream
    repeat (GAP_AFTER) begin
      draw_sample(s);
      send_sample(s);
    end
    idle_cycles(FLUSH_CYCLES);
    report_test();

    start_test("extreme");
    repeat (EXTREME_RUN) send_sample(FULL_POS);
    repeat (EXTREME_RUN) send_sample(FULL_NEG);
    for (int k = 0; k < EXTREME_RUN; k++) begin
      send_sample((FIR_COEFS[k % NUM_TAPS] < 0) ? FULL_NEG : FULL_POS);  // Follow tap signs
    end
    idle_cycles(FLUSH_CYCLES);
    report_test();

    $display("tests %0d failed %0d checks %0d errors %0d",
             tests_run, tests_failed, check_count, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- all.f
fas_pkg.sv
fir_filter.sv
frame_assembler.sv
fas_top.sv
tb_clock_gen.sv
tb_fas.sv

//--- Makefile
# Verilator build for the FIR filter and frame assembler

VERILATOR ?= verilator
TOP       ?= tb_fas
RTL_TOP   ?= fas_top
FILELIST  ?= all.f
RTL_SRCS  ?= fas_pkg.sv fir_filter.sv frame_assembler.sv fas_top.sv
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= FAIL: see errors above

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRCS)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); test $$status -eq 0
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
